// ==== project.f ====
source/mz_bus_pkg.sv
source/heartbeat.sv
source/word_buffer.sv
source/ctrl_regs.sv
source/word_sum.sv
source/mz_bus_ctrl.sv
source/mz_fpga_top.sv
tb/mz_bus_props.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top -Mdir obj_dir
out=$(./obj_dir/Vtb_top +verilator+error+limit+1000)
echo "$out"
if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import mz_bus_pkg::*;

  logic                  FPGA_CLK3      = 1'b0;
  logic                  SYS_RST_N      = 1'b0;
  logic [ADDR_W-1:0]     mz_buf_addr    = '0;
  logic [DATA_W-1:0]     mz_buf_data_in = '0;
  logic                  mz_cpld_as     = 1'b0;
  logic                  mz_cpld_rw     = 1'b0;
  logic [BYTE_LANES-1:0] mz_cpld_byte_n = '1;   // No lanes
  logic [DATA_W-1:0]     mz_buf_data_out;
  logic                  mz_buf_data_oe;
  logic                  fpga_mz_dtack;
  logic                  vd_start;
  logic [1:0]            led;

  logic [31:0]       rng = 32'h7130e2dc;        // Xorshift state
  int                errors = 0;
  int                checks = 0;
  logic [DATA_W-1:0] rd_word;                   // Last word read by the host
  logic [DATA_W-1:0] reg_model [10];            // Expected register contents

  mz_fpga_top i_mz_fpga_top (.*);

  always #2 FPGA_CLK3 = ~FPGA_CLK3;             // 4 ns

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Offset 0x00, then 0x10 up to 0x30 by 4
  function automatic logic [ADDR_W-1:0] reg_addr(input int i);
    return (i == 0) ? 24'h0 : 24'(8'h0C + 4 * i);
  endfunction

  function automatic logic [ADDR_W-1:0] buf_addr(input logic [WORD_IDX_W-1:0] idx);
    return {8'h00, 4'h1, 1'b0, idx, 2'b00};      // Region 1 is the buffer
  endfunction

  task automatic next_cycle();
    @(posedge FPGA_CLK3);
    #1;                                         // Drive and sample after the edge
  endtask

  // --------------------
  task automatic bus_access(input logic rd, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [3:0] byte_n);
    int n;
    mz_buf_addr    = addr;
    mz_buf_data_in = data;
    mz_cpld_rw     = rd;
    mz_cpld_byte_n = byte_n;
    mz_cpld_as     = 1'b1;
    n = 0;
    while (!fpga_mz_dtack && n < 20) begin
      next_cycle();
      n++;
    end
    if (!fpga_mz_dtack) begin
      $display("Timeout: no DTACK within 20 clocks for address %h", addr);
      errors++;
    end
    rd_word    = mz_buf_data_out;               // Latched before DTACK
    mz_cpld_as = 1'b0;
    mz_cpld_rw = 1'b0;
    n = 0;
    while (fpga_mz_dtack && n < 4) begin
      next_cycle();
      n++;
    end
    if (fpga_mz_dtack) begin
      $display("Timeout: DTACK stayed high after the strobe was released");
      errors++;
    end
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic test_done(input string name);
    $display("%s finished, %0d errors so far", name, errors);
  endtask

  // --------------------
  initial begin
    logic [DATA_W-1:0] a_val;
    logic [DATA_W-1:0] b_val;
    logic [DATA_W-1:0] exp_val;
    logic [3:0]        lanes_n;
    repeat (3) @(posedge FPGA_CLK3);
    #1 SYS_RST_N = 1'b1;
    check_value("reset", 32'h0, {27'h0, fpga_mz_dtack, mz_buf_data_oe, vd_start, led});
    test_done("reset");

    for (int i = 0; i < 10; i++) begin
      reg_model[i] = next_random();
      bus_access(1'b0, reg_addr(i), reg_model[i], 4'h0);
    end
    for (int i = 0; i < 10; i++) begin
      bus_access(1'b1, reg_addr(i), '0, 4'hF);
      check_value("register readback", reg_model[i], rd_word);
    end
    bus_access(1'b0, 24'h000004, next_random(), 4'h0);   // Hole in the map
    bus_access(1'b1, 24'h000004, '0, 4'hF);
    check_value("undefined offset", 32'h0, rd_word);
    bus_access(1'b0, reg_addr(0), next_random() | 32'h1, 4'h0);
    check_value("start level high", 32'h3, {30'h0, vd_start, led[1]});
    bus_access(1'b0, reg_addr(0), next_random() & ~32'h1, 4'h0);
    check_value("start level low", 32'h0, {30'h0, vd_start, led[1]});
    test_done("control registers");

    for (int k = 0; k < 2; k++) begin
      lanes_n = k ? 4'b1110 : 4'b0101;          // High means lane kept
      a_val   = next_random();
      b_val   = next_random();
      bus_access(1'b0, buf_addr(9'd37 + 9'(k)), a_val, 4'h0);
      bus_access(1'b0, buf_addr(9'd37 + 9'(k)), b_val, lanes_n);
      for (int i = 0; i < BYTE_LANES; i++) begin
        exp_val[i*8 +: 8] = lanes_n[i] ? a_val[i*8 +: 8] : b_val[i*8 +: 8];
      end
      bus_access(1'b1, buf_addr(9'd37 + 9'(k)), '0, 4'hF);
      check_value("byte lanes", exp_val, rd_word);
    end
    test_done("byte lanes");

    a_val = next_random();
    b_val = next_random();
    bus_access(1'b0, buf_addr(9'd1), a_val, 4'h0);
    bus_access(1'b0, buf_addr(9'd2), b_val, 4'h0);
    exp_val = a_val + b_val;                    // Modulo 2^32
    bus_access(1'b1, buf_addr(9'd0), '0, 4'hF);
    check_value("sum read", exp_val, rd_word);
    bus_access(1'b0, buf_addr(9'd0), next_random(), 4'h0);
    bus_access(1'b1, buf_addr(9'd0), '0, 4'hF);
    check_value("sum after word 0 write", exp_val, rd_word);
    test_done("sum read");

    repeat (4 * HEARTBEAT_PERIOD) next_cycle();  // Several LED periods
    errors += int'(i_mz_fpga_top.i_mz_bus_props.fail_cnt);
    test_done("protocol");
    test_done("heartbeat");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/mz_bus_props.sv ====
`timescale 1ns/1ps

module mz_bus_props (
  input logic       FPGA_CLK3,
  input logic       SYS_RST_N,
  input logic       mz_cpld_as,
  input logic       mz_cpld_rw,
  input logic       mz_buf_data_oe,
  input logic       fpga_mz_dtack,
  input logic [1:0] led
);
  import mz_bus_pkg::*;

  int unsigned fail_cnt = 0;                 // Failed assertions, read by tb_top
  logic        beat_q;                       // LED one clock back
  int unsigned since_beat;                   // Clocks since last LED change

  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      beat_q     <= 1'b0;
      since_beat <= 0;
    end else begin
      beat_q     <= led[0];
      since_beat <= (led[0] != beat_q) ? 1 : since_beat + 1;  // Restart on change
    end
  end

  // --------------------
  a_dtack_needs_as: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    !mz_cpld_as |=> !$rose(fpga_mz_dtack)) else begin
    fail_cnt++;
    $error("DTACK rose while the strobe was low");
  end

  a_dtack_release: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    $fell(mz_cpld_as) |-> ##2 !fpga_mz_dtack) else begin
    fail_cnt++;
    $error("DTACK still high two clocks after the strobe fell");
  end

  a_data_oe: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    mz_buf_data_oe == (mz_cpld_rw && mz_cpld_as)) else begin
    fail_cnt++;
    $error("Data output enable differs from read and strobe");
  end

  // LED changes exactly when a full period has gone by
  a_heartbeat: assert property (@(posedge FPGA_CLK3) disable iff (!SYS_RST_N)
    (led[0] != beat_q) == (since_beat == HEARTBEAT_PERIOD)) else begin
    fail_cnt++;
    $error("Heartbeat LED period is not %0d clocks", HEARTBEAT_PERIOD);
  end

endmodule

bind mz_fpga_top mz_bus_props i_mz_bus_props (.*);

// ==== source/mz_fpga_top.sv ====
`timescale 1ns/1ps

module mz_fpga_top (
  input  logic                              FPGA_CLK3,
  input  logic                              SYS_RST_N,
  input  logic [mz_bus_pkg::ADDR_W-1:0]     mz_buf_addr,
  input  logic [mz_bus_pkg::DATA_W-1:0]     mz_buf_data_in,
  input  logic                              mz_cpld_as,       // Strobe, active high
  input  logic                              mz_cpld_rw,       // 1 means read
  input  logic [mz_bus_pkg::BYTE_LANES-1:0] mz_cpld_byte_n,
  output logic [mz_bus_pkg::DATA_W-1:0]     mz_buf_data_out,
  output logic                              mz_buf_data_oe,
  output logic                              fpga_mz_dtack,
  output logic                              vd_start,
  output logic [1:0]                        led               // Start, heartbeat
);
  import mz_bus_pkg::*;

  logic                  reg_we;
  logic [REG_OFS_W-1:0]  reg_ofs;
  logic [DATA_W-1:0]     wdata;
  logic [DATA_W-1:0]     reg_rdata;
  logic                  buf_en;
  logic [BYTE_LANES-1:0] buf_be;
  logic [WORD_IDX_W-1:0] buf_idx;
  logic [DATA_W-1:0]     buf_rdata;
  logic                  sum_start;
  logic                  sum_rd_en;
  logic [WORD_IDX_W-1:0] sum_rd_idx;
  logic                  sum_done;
  logic [DATA_W-1:0]     sum_value;

  // --------------------
  mz_bus_ctrl i_mz_bus_ctrl (.*);

  ctrl_regs i_ctrl_regs (.*);

  word_buffer i_word_buffer (.*);

  word_sum i_word_sum (.*);

  heartbeat i_heartbeat (
    .FPGA_CLK3 (FPGA_CLK3),
    .SYS_RST_N (SYS_RST_N),
    .led_beat  (led[0])
  );

  assign led[1] = vd_start;                  // Start level on second LED

endmodule

// ==== source/mz_bus_ctrl.sv ====
`timescale 1ns/1ps

module mz_bus_ctrl (
  input  logic                              FPGA_CLK3,
  input  logic                              SYS_RST_N,
  input  logic [mz_bus_pkg::ADDR_W-1:0]     mz_buf_addr,
  input  logic [mz_bus_pkg::DATA_W-1:0]     mz_buf_data_in,
  input  logic                              mz_cpld_as,
  input  logic                              mz_cpld_rw,
  input  logic [mz_bus_pkg::BYTE_LANES-1:0] mz_cpld_byte_n,
  output logic [mz_bus_pkg::DATA_W-1:0]     mz_buf_data_out,
  output logic                              mz_buf_data_oe,
  output logic                              fpga_mz_dtack,
  output logic                              reg_we,
  output logic [mz_bus_pkg::REG_OFS_W-1:0]  reg_ofs,
  output logic [mz_bus_pkg::DATA_W-1:0]     wdata,
  input  logic [mz_bus_pkg::DATA_W-1:0]     reg_rdata,
  output logic                              buf_en,
  output logic [mz_bus_pkg::BYTE_LANES-1:0] buf_be,
  output logic [mz_bus_pkg::WORD_IDX_W-1:0] buf_idx,
  input  logic [mz_bus_pkg::DATA_W-1:0]     buf_rdata,
  output logic                              sum_start,
  input  logic                              sum_rd_en,
  input  logic [mz_bus_pkg::WORD_IDX_W-1:0] sum_rd_idx,
  input  logic                              sum_done,
  input  logic [mz_bus_pkg::DATA_W-1:0]     sum_value
);
  import mz_bus_pkg::*;

  logic [1:0]            as_sync;            // Strobe synchronizer
  logic                  as_detected;
  logic [2:0]            state;
  logic                  dtack;
  mz_addr_t              addr_q;             // Latched address
  logic [DATA_W-1:0]     wdata_q;
  logic                  rw_q;               // 1 means read
  logic [BYTE_LANES-1:0] byte_n_q;
  logic [DATA_W-1:0]     rdata_q;            // Word returned to host
  logic                  is_reg;
  logic                  is_sum_rd;

  // --------------------
  // Strobe detect
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      as_sync <= '0;
    end else begin
      as_sync <= {as_sync[0], mz_cpld_as};
    end
  end

  // Both flops and the pin high, drops with the pin
  assign as_detected = as_sync[1] & as_sync[0] & mz_cpld_as;

  // Access capture on detection
  always_ff @(posedge FPGA_CLK3) begin
    if ((state == CS_IDLE) && as_detected) begin
      addr_q   <= mz_buf_addr;
      wdata_q  <= mz_buf_data_in;
      rw_q     <= mz_cpld_rw;
      byte_n_q <= mz_cpld_byte_n;
    end
  end

  assign is_reg    = (addr_q.regs.region == 4'h0);                     // Register window
  assign is_sum_rd = rw_q && !is_reg && (addr_q.mem.idx == SUM_WORD_IDX);

  // --------------------
  // Access FSM
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      state <= CS_IDLE;
      dtack <= 1'b0;
    end else begin
      case (state)
        CS_IDLE: begin
          dtack <= 1'b0;
          if (as_detected) state <= CS_ACCESS;
        end
        CS_ACCESS:  state <= CS_WAIT;                        // Strobes issued here
        CS_WAIT:    state <= rw_q ? CS_CAPTURE : CS_ACK;     // Writes skip capture
        CS_CAPTURE: state <= is_sum_rd ? CS_SUM : CS_ACK;
        CS_SUM:     if (sum_done) state <= CS_ACK;           // Sequencer owns buffer
        CS_ACK: begin
          dtack <= 1'b1;
          state <= CS_RELEASE;
        end
        CS_RELEASE: begin
          if (!as_detected) begin                            // Host let go
            dtack <= 1'b0;
            state <= CS_IDLE;
          end
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  // Read data latch
  always_ff @(posedge FPGA_CLK3) begin
    if (state == CS_CAPTURE) begin
      rdata_q <= is_reg ? reg_rdata : buf_rdata;
    end else if ((state == CS_SUM) && sum_done) begin
      rdata_q <= sum_value;                                  // Word 0 reads the sum
    end
  end

  // --------------------
  // Routing
  assign reg_we    = (state == CS_ACCESS) && is_reg && !rw_q;
  assign reg_ofs   = addr_q.regs.ofs;
  assign wdata     = wdata_q;
  assign buf_en    = (state == CS_SUM) ? sum_rd_en : ((state == CS_ACCESS) && !is_reg);
  assign buf_be    = ((state == CS_ACCESS) && !rw_q) ? ~byte_n_q : '0;  // Enables active high
  assign buf_idx   = (state == CS_SUM) ? sum_rd_idx : addr_q.mem.idx;
  assign sum_start = (state == CS_CAPTURE) && is_sum_rd;

  // Host side
  assign mz_buf_data_out = rdata_q;
  assign mz_buf_data_oe  = mz_cpld_rw & mz_cpld_as;          // Drive only during read strobe
  assign fpga_mz_dtack   = dtack;

endmodule

// ==== source/word_sum.sv ====
`timescale 1ns/1ps

module word_sum (
  input  logic                              FPGA_CLK3,
  input  logic                              SYS_RST_N,
  input  logic                              sum_start,
  output logic                              sum_rd_en,
  output logic [mz_bus_pkg::WORD_IDX_W-1:0] sum_rd_idx,
  input  logic [mz_bus_pkg::DATA_W-1:0]     buf_rdata,
  output logic                              sum_done,
  output logic [mz_bus_pkg::DATA_W-1:0]     sum_value
);
  import mz_bus_pkg::*;

  logic [2:0]        state;
  logic [DATA_W-1:0] op_a;                   // First operand, word 1

  // --------------------
  // Two reads, one add
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      state <= SS_IDLE;
    end else begin
      case (state)
        SS_IDLE:  if (sum_start) state <= SS_RD_A;
        SS_RD_A:  state <= SS_CAP_A;         // Buffer fetches word 1
        SS_CAP_A: state <= SS_RD_B;
        SS_RD_B:  state <= SS_ADD;           // Buffer fetches word 2
        SS_ADD:   state <= SS_DONE;
        SS_DONE:  state <= SS_IDLE;
        default:  state <= SS_IDLE;
      endcase
    end
  end

  always_ff @(posedge FPGA_CLK3) begin
    if (state == SS_CAP_A) begin
      op_a <= buf_rdata;
    end
    if (state == SS_ADD) begin
      sum_value <= op_a + buf_rdata;         // Wraps modulo 2^32
    end
  end

  assign sum_rd_en  = (state == SS_RD_A) || (state == SS_RD_B);
  assign sum_rd_idx = (state == SS_RD_A) ? SUM_A_IDX : SUM_B_IDX;
  assign sum_done   = (state == SS_DONE);    // One clock, sum_value valid

endmodule

// ==== source/ctrl_regs.sv ====
`timescale 1ns/1ps

module ctrl_regs (
  input  logic                             FPGA_CLK3,
  input  logic                             SYS_RST_N,
  input  logic                             reg_we,
  input  logic [mz_bus_pkg::REG_OFS_W-1:0] reg_ofs,
  input  logic [mz_bus_pkg::DATA_W-1:0]    wdata,
  output logic [mz_bus_pkg::DATA_W-1:0]    reg_rdata,
  output logic                             vd_start
);
  import mz_bus_pkg::*;

  logic [DATA_W-1:0] run_q;                           // Run register
  logic [DATA_W-1:0] ncs_q, nct_q, n1_q, n2_q;        // Decoder arguments
  logic [DATA_W-1:0] nnobpa_q, nnobpb_q, pppa_q, pppb_q, lvl_q;

  // --------------------
  // Write decode
  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      run_q    <= '0;
      ncs_q    <= '0;
      nct_q    <= '0;
      n1_q     <= '0;
      n2_q     <= '0;
      nnobpa_q <= '0;
      nnobpb_q <= '0;
      pppa_q   <= '0;
      pppb_q   <= '0;
      lvl_q    <= '0;
    end else if (reg_we) begin
      case (reg_ofs)
        REG_RUN_OFS:    run_q    <= wdata;
        REG_NCS_OFS:    ncs_q    <= wdata;
        REG_NCT_OFS:    nct_q    <= wdata;
        REG_N1_OFS:     n1_q     <= wdata;
        REG_N2_OFS:     n2_q     <= wdata;
        REG_NNOBPA_OFS: nnobpa_q <= wdata;
        REG_NNOBPB_OFS: nnobpb_q <= wdata;
        REG_PPPA_OFS:   pppa_q   <= wdata;
        REG_PPPB_OFS:   pppb_q   <= wdata;
        REG_LVL_OFS:    lvl_q    <= wdata;
        default: ;                                    // Holes drop the write
      endcase
    end
  end

  // Read-back
  always_comb begin
    case (reg_ofs)
      REG_RUN_OFS:    reg_rdata = run_q;
      REG_NCS_OFS:    reg_rdata = ncs_q;
      REG_NCT_OFS:    reg_rdata = nct_q;
      REG_N1_OFS:     reg_rdata = n1_q;
      REG_N2_OFS:     reg_rdata = n2_q;
      REG_NNOBPA_OFS: reg_rdata = nnobpa_q;
      REG_NNOBPB_OFS: reg_rdata = nnobpb_q;
      REG_PPPA_OFS:   reg_rdata = pppa_q;
      REG_PPPB_OFS:   reg_rdata = pppb_q;
      REG_LVL_OFS:    reg_rdata = lvl_q;
      default:        reg_rdata = '0;                 // Holes read zero
    endcase
  end

  assign vd_start = run_q[0];                         // Decoder start level

endmodule

// ==== source/word_buffer.sv ====
`timescale 1ns/1ps

module word_buffer (
  input  logic                              FPGA_CLK3,
  input  logic                              buf_en,
  input  logic [mz_bus_pkg::BYTE_LANES-1:0] buf_be,
  input  logic [mz_bus_pkg::WORD_IDX_W-1:0] buf_idx,
  input  logic [mz_bus_pkg::DATA_W-1:0]     wdata,
  output logic [mz_bus_pkg::DATA_W-1:0]     buf_rdata
);
  import mz_bus_pkg::*;

  logic [DATA_W-1:0] mem [2**WORD_IDX_W];    // Block RAM, no init

  // --------------------
  // Lane writes
  always_ff @(posedge FPGA_CLK3) begin
    if (buf_en) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (buf_be[i]) begin
          mem[buf_idx][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];  // Only enabled bytes
        end
      end
    end
  end

  // Read port, data one clock after an enable with no lane set
  always_ff @(posedge FPGA_CLK3) begin
    if (buf_en && (buf_be == '0)) begin
      buf_rdata <= mem[buf_idx];             // Held until next read
    end
  end

endmodule

// ==== source/heartbeat.sv ====
`timescale 1ns/1ps

module heartbeat (
  input  logic FPGA_CLK3,
  input  logic SYS_RST_N,
  output logic led_beat
);
  import mz_bus_pkg::*;

  logic [$clog2(HEARTBEAT_PERIOD)-1:0] cnt;  // Clocks since last toggle

  always_ff @(posedge FPGA_CLK3 or negedge SYS_RST_N) begin
    if (!SYS_RST_N) begin
      cnt      <= '0;
      led_beat <= 1'b0;
    end else if (cnt == HEARTBEAT_PERIOD - 1) begin
      cnt      <= '0;                        // Wrap
      led_beat <= ~led_beat;                 // Toggle once per period
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== source/mz_bus_pkg.sv ====
package mz_bus_pkg;

  // --------------------
  // Bus geometry
  localparam int ADDR_W     = 24;                          // Host address bus
  localparam int DATA_W     = 32;                          // Host data bus
  localparam int BYTE_LANES = 4;                           // One enable per byte
  localparam int LANE_W     = DATA_W / BYTE_LANES;         // Bits per lane
  localparam int WORD_IDX_W = 9;                           // 512 buffer words
  localparam int REG_OFS_W  = 8;                           // Register window

  // --------------------
  // Control register map
  localparam logic [REG_OFS_W-1:0] REG_RUN_OFS    = 8'h00; // Run, bit 0 starts decoder
  localparam logic [REG_OFS_W-1:0] REG_NCS_OFS    = 8'h10; // Coding scheme
  localparam logic [REG_OFS_W-1:0] REG_NCT_OFS    = 8'h14; // Channel type
  localparam logic [REG_OFS_W-1:0] REG_N1_OFS     = 8'h18;
  localparam logic [REG_OFS_W-1:0] REG_N2_OFS     = 8'h1C;
  localparam logic [REG_OFS_W-1:0] REG_NNOBPA_OFS = 8'h20; // Out bits, part A
  localparam logic [REG_OFS_W-1:0] REG_NNOBPB_OFS = 8'h24; // Out bits, part B
  localparam logic [REG_OFS_W-1:0] REG_PPPA_OFS   = 8'h28; // Puncture pattern A
  localparam logic [REG_OFS_W-1:0] REG_PPPB_OFS   = 8'h2C; // Puncture pattern B
  localparam logic [REG_OFS_W-1:0] REG_LVL_OFS    = 8'h30; // Level

  // Summing window in the buffer
  localparam logic [WORD_IDX_W-1:0] SUM_WORD_IDX = 9'd0;   // Read returns the sum
  localparam logic [WORD_IDX_W-1:0] SUM_A_IDX    = 9'd1;
  localparam logic [WORD_IDX_W-1:0] SUM_B_IDX    = 9'd2;

  localparam int HEARTBEAT_PERIOD = 16;                    // Clocks per LED toggle

  // --------------------
  // Bus controller states
  localparam logic [2:0] CS_IDLE    = 3'd0;
  localparam logic [2:0] CS_ACCESS  = 3'd1;
  localparam logic [2:0] CS_WAIT    = 3'd2;
  localparam logic [2:0] CS_CAPTURE = 3'd3;
  localparam logic [2:0] CS_ACK     = 3'd4;
  localparam logic [2:0] CS_RELEASE = 3'd5;
  localparam logic [2:0] CS_SUM     = 3'd6;

  // Sum sequencer states
  localparam logic [2:0] SS_IDLE  = 3'd0;
  localparam logic [2:0] SS_RD_A  = 3'd1;
  localparam logic [2:0] SS_CAP_A = 3'd2;
  localparam logic [2:0] SS_RD_B  = 3'd3;
  localparam logic [2:0] SS_ADD   = 3'd4;
  localparam logic [2:0] SS_DONE  = 3'd5;

  // Same address word, seen as register access or buffer access
  typedef union packed {
    struct packed {
      logic [7:0]           page;    // Not decoded
      logic [3:0]           region;  // Zero selects registers
      logic [3:0]           pad;
      logic [REG_OFS_W-1:0] ofs;
    } regs;
    struct packed {
      logic [7:0]            page;
      logic [3:0]            region;
      logic                  pad;
      logic [WORD_IDX_W-1:0] idx;    // Word in buffer
      logic [1:0]            lane;   // Byte address, lanes use enables
    } mem;
  } mz_addr_t;

endpackage
